// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pov_display
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

SOURCES := $(wildcard design/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/col_calc.sv
`timescale 1ns/100ps
`default_nettype none

// picks which pair indices get redrawn at this angle
// inner pairs sweep a short arc per step, so they are refreshed less often
module col_calc
    import pov_pkg::*;
(
    input  wire theta_t dtheta,
    output col_mask_t   col_mask
);

    always_comb begin
        int ring;   // 0 = innermost 8 pairs, 3 = outermost
        int shift;  // number of low angle bits that must be zero
        int low;    // those low angle bits
        for (int i = 0; i < SCAN_RATE; i++) begin
            ring  = i / 8;
            shift = 3 - ring;                       // 3, 2, 1, 0
            low   = int'(dtheta) & ((1 << shift) - 1);
            col_mask[i] = (low == 0);              // ring 3 always true
        end
    end

endmodule

`default_nettype wire

// File: design/cube_frame.sv
`timescale 1ns/100ps
`default_nettype none

// square outline, edge two doubled units thick
// half-width follows the angle so the box breathes as it spins
module cube_frame
    import pov_pkg::*;
(
    input  wire theta_t   dtheta,
    input  wire col_idx_t col_idx,
    output col_pair_t     columns
);

    always_comb begin
        int w;        // half-width in pixels, 16..31
        int edge_lo;  // inner edge of outline, doubled coords
        int edge_hi;  // outer edge
        int c;
        int dx;
        int dy;
        int adx;
        int ady;
        logic on_v;   // vertical sides
        logic on_h;   // horizontal sides
        w       = 16 + int'(dtheta[4:0] >> 1);
        edge_lo = 2 * w - 1;
        edge_hi = 2 * w + 1;
        for (int k = 0; k < 2; k++) begin
            c   = int'(col_idx) + k * SCAN_RATE;
            dx  = 2 * c - (NUM_COLS - 1);
            adx = (dx < 0) ? -dx : dx;
            for (int r = 0; r < NUM_ROWS; r++) begin
                dy   = 2 * r - (NUM_ROWS - 1);
                ady  = (dy < 0) ? -dy : dy;
                on_v = (adx >= edge_lo) && (adx <= edge_hi) && (ady <= edge_hi);
                on_h = (ady >= edge_lo) && (ady <= edge_hi) && (adx <= edge_hi);
                if (on_v || on_h) begin
                    columns[k][r] = CUBE_COLOR;
                end else begin
                    columns[k][r] = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/frame_manager.sv
`timescale 1ns/100ps
`default_nettype none

// walks the pair indices, one per cycle while armed
// hands the first refreshed pair it finds to the driver
module frame_manager
    import pov_pkg::*;
(
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire mode_t  mode,
    input  wire theta_t dtheta,
    input  wire         hub75_ready,   // level, high while driver idle
    output col_pair_t   columns,
    output col_idx_t    col_num,
    output logic        data_valid     // one cycle per pair
);

    col_idx_t  scan_idx;   // index under test this cycle
    logic      ready_d;    // for edge detect
    logic      armed;      // allowed to issue one pair
    logic      ready_rise;
    logic      issue;      // this index goes out
    col_mask_t col_mask;

    pixel_t    cyl_pixel;
    col_pair_t cyl_cols;
    col_pair_t sphere_cols;
    col_pair_t cube_cols;
    col_pair_t star_cols;
    col_pair_t scene_cols;

    col_calc col_calc_inst (
        .dtheta   (dtheta),
        .col_mask (col_mask)
    );

    sphere_frame sphere_frame_inst ( // angle independent
        .col_idx (scan_idx),
        .columns (sphere_cols)
    );

    cube_frame cube_frame_inst (
        .dtheta  (dtheta),
        .col_idx (scan_idx),
        .columns (cube_cols)
    );

    starfield_frame starfield_frame_inst (
        .dtheta  (dtheta),
        .col_idx (scan_idx),
        .columns (star_cols)
    );

    // cylinder: angle bits straight into rgb, blue lsb forced on
    assign cyl_pixel = {dtheta[7:5], dtheta[4:2], dtheta[1:0], 1'b1};
    assign cyl_cols  = {(2 * NUM_ROWS){cyl_pixel}};

    always_comb begin
        case (mode)
            MODE_CYLINDER:  scene_cols = cyl_cols;
            MODE_SPHERE:    scene_cols = sphere_cols;
            MODE_CUBE:      scene_cols = cube_cols;
            MODE_STARFIELD: scene_cols = star_cols;
            default:        scene_cols = cyl_cols;
        endcase
    end

    assign ready_rise = hub75_ready & ~ready_d;
    assign issue      = armed & hub75_ready & col_mask[scan_idx];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            scan_idx   <= '0;
            ready_d    <= 1'b0;
            armed      <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            ready_d    <= hub75_ready;
            data_valid <= issue;   // pulse the cycle after capture
            if (ready_rise) begin
                armed <= 1'b1;
            end else if (issue) begin
                armed <= 1'b0;     // one pair per ready period
            end
            if (armed && hub75_ready) begin
                scan_idx <= scan_idx + 1'b1; // 31 wraps to 0
            end
        end
    end

    // pair payload, held until the next issue
    always_ff @(posedge clk_in) begin
        if (issue) begin
            columns <= scene_cols;
            col_num <= scan_idx;
        end
    end

endmodule

`default_nettype wire

// File: design/hub75_driver.sv
`timescale 1ns/100ps
`default_nettype none

// clocks one column pair into the panel shift registers, then latches it
// rgb0 carries column idx, rgb1 column idx+32
module hub75_driver
    import pov_pkg::*;
(
    input  wire            clk_in,
    input  wire            rst_in,
    input  wire col_pair_t columns,
    input  wire col_idx_t  col_num,
    input  wire            data_valid,
    output logic           hub75_ready,
    output pixel_t         hub_rgb0,
    output pixel_t         hub_rgb1,
    output logic           hub_clk,
    output logic           hub_lat,
    output logic           hub_oe,     // active low
    output col_idx_t       hub_addr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_LATCH
    } state_t;

    state_t state;
    logic [$clog2(NUM_ROWS)-1:0] row;   // row being shifted
    logic      phase;                   // 0 setup, 1 clock high
    col_pair_t cols_q;                  // captured pair
    col_idx_t  addr_q;

    // data held for both phases of a row
    assign hub_rgb0 = cols_q[0][row];
    assign hub_rgb1 = cols_q[1][row];
    assign hub_clk  = (state == ST_SHIFT) && phase; // second cycle of row
    assign hub_addr = addr_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= ST_IDLE;
            row         <= '0;
            phase       <= 1'b0;
            hub75_ready <= 1'b0;  // rises first cycle after release
            hub_lat     <= 1'b0;
            hub_oe      <= 1'b1;  // dark until something is latched
        end else begin
            case (state)
                ST_IDLE: begin
                    if (data_valid) begin
                        state       <= ST_SHIFT;
                        row         <= '0;
                        phase       <= 1'b0;
                        hub75_ready <= 1'b0;
                        hub_oe      <= 1'b0;
                    end else begin
                        hub75_ready <= 1'b1;
                    end
                end
                ST_SHIFT: begin
                    phase <= ~phase;
                    if (phase) begin
                        row <= row + 1'b1;
                        if (row == NUM_ROWS - 1) begin // last clock pulse
                            state   <= ST_LATCH;
                            hub_lat <= 1'b1;
                            hub_oe  <= 1'b1;           // blank while latching
                        end
                    end
                end
                ST_LATCH: begin
                    state       <= ST_IDLE;
                    hub_lat     <= 1'b0;
                    hub_oe      <= 1'b0;
                    hub75_ready <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk_in) begin
        if (state == ST_IDLE && data_valid) begin
            cols_q <= columns;
            addr_q <= col_num;
        end
    end

endmodule

`default_nettype wire

// File: design/pov_display_top.sv
`timescale 1ns/100ps
`default_nettype none

// column path: scene render -> HUB75 shift out
module pov_display_top
    import pov_pkg::*;
(
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire mode_t  mode,
    input  wire theta_t dtheta,     // from rotation sensor
    output pixel_t      hub_rgb0,
    output pixel_t      hub_rgb1,
    output logic        hub_clk,
    output logic        hub_lat,
    output logic        hub_oe,
    output col_idx_t    hub_addr
);

    logic      hub75_ready;
    col_pair_t columns;
    col_idx_t  col_num;
    logic      data_valid;

    frame_manager frame_manager_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .mode        (mode),
        .dtheta      (dtheta),
        .hub75_ready (hub75_ready),
        .columns     (columns),
        .col_num     (col_num),
        .data_valid  (data_valid)
    );

    hub75_driver hub75_driver_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .columns     (columns),
        .col_num     (col_num),
        .data_valid  (data_valid),
        .hub75_ready (hub75_ready),
        .hub_rgb0    (hub_rgb0),
        .hub_rgb1    (hub_rgb1),
        .hub_clk     (hub_clk),
        .hub_lat     (hub_lat),
        .hub_oe      (hub_oe),
        .hub_addr    (hub_addr)
    );

endmodule

`default_nettype wire

// File: design/pov_pkg.sv
`default_nettype none

package pov_pkg;

    // panel and rotation geometry
    localparam int ROT_RES   = 256; // angle steps per turn
    localparam int NUM_ROWS  = 64;  // pixels per column
    localparam int NUM_COLS  = 64;  // physical columns
    localparam int SCAN_RATE = 32;  // column pairs, idx and idx+32
    localparam int RGB_RES   = 9;   // 3 red, 3 green, 3 blue

    // angle and pair index
    typedef logic [$clog2(ROT_RES)-1:0]   theta_t;
    typedef logic [$clog2(SCAN_RATE)-1:0] col_idx_t;

    // pixel payloads
    typedef logic [RGB_RES-1:0]                       pixel_t;
    typedef logic [NUM_ROWS-1:0][RGB_RES-1:0]         column_t;
    // [0] is column idx, [1] is column idx+32
    typedef logic [1:0][NUM_ROWS-1:0][RGB_RES-1:0]    col_pair_t;

    // one refresh flag per pair index
    typedef logic [SCAN_RATE-1:0] col_mask_t;

    typedef enum logic [1:0] {
        MODE_CYLINDER  = 2'd0,
        MODE_SPHERE    = 2'd1,
        MODE_CUBE      = 2'd2,
        MODE_STARFIELD = 2'd3
    } mode_t;

    // scene colours, rrr_ggg_bbb
    localparam pixel_t SPHERE_COLOR = 9'h1ff; // white
    localparam pixel_t CUBE_COLOR   = 9'h038; // green
    localparam pixel_t STAR_COLOR   = 9'h1c7; // magenta-ish

endpackage

`default_nettype wire

// File: design/sphere_frame.sv
`timescale 1ns/100ps
`default_nettype none

// filled disc seen from the side of the cylinder of rotation
// every angle shows the same disc, so it's a sphere once spun
module sphere_frame
    import pov_pkg::*;
(
    input  wire col_idx_t col_idx,
    output col_pair_t     columns
);

    localparam int RADIUS_SQ = (NUM_ROWS - 1) * (NUM_ROWS - 1); // 63^2 in doubled coords

    always_comb begin
        int c;   // physical column
        int dx;  // doubled offset from centre, odd
        int dy;
        for (int k = 0; k < 2; k++) begin
            c  = int'(col_idx) + k * SCAN_RATE; // second column sits half a panel over
            dx = 2 * c - (NUM_COLS - 1);
            for (int r = 0; r < NUM_ROWS; r++) begin
                dy = 2 * r - (NUM_ROWS - 1);
                if (dx * dx + dy * dy <= RADIUS_SQ) begin
                    columns[k][r] = SPHERE_COLOR;
                end else begin
                    columns[k][r] = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/starfield_frame.sv
`timescale 1ns/100ps
`default_nettype none

// cheap linear hash per pixel, lit when it lands in the bottom 8 of 256
// adding the angle slides the pattern along rows as the panel turns
module starfield_frame
    import pov_pkg::*;
(
    input  wire theta_t   dtheta,
    input  wire col_idx_t col_idx,
    output col_pair_t     columns
);

    always_comb begin
        int c;
        int sum;           // unreduced hash
        logic [7:0] h;     // mod 256
        for (int k = 0; k < 2; k++) begin
            c = int'(col_idx) + k * SCAN_RATE;
            for (int r = 0; r < NUM_ROWS; r++) begin
                sum = 37 * r + 11 * c + int'(dtheta);
                h   = sum[7:0];          // keep low byte only
                // top five bits clear -> 1 in 32 pixels lit
                if (h[7:3] == 5'd0) begin
                    columns[k][r] = STAR_COLOR;
                end else begin
                    columns[k][r] = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+testbench
design/pov_pkg.sv
design/col_calc.sv
design/sphere_frame.sv
design/cube_frame.sv
design/starfield_frame.sv
design/frame_manager.sv
design/hub75_driver.sv
design/pov_display_top.sv
testbench/tb_pov_display.sv

// File: testbench/tb_pov_models.svh
`ifndef TB_POV_MODELS_SVH
`define TB_POV_MODELS_SVH

// outer ring every step, then every 2, 4 and 8 steps going inwards
function automatic bit refresh_at(input theta_t th, input int idx);
    int step;
    step = 1 << (3 - idx / 8);
    return (int'(th) % step) == 0;
endfunction

// first refreshed pair at or after start, wraps at 32
function automatic col_idx_t next_refreshed(input theta_t th, input int start);
    int idx;
    idx = start % SCAN_RATE;
    while (!refresh_at(th, idx)) begin
        idx = (idx + 1) % SCAN_RATE;
    end
    return col_idx_t'(idx);
endfunction

function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
endfunction

// a on the edge band of the square, b inside its span
function automatic bit on_side(input int a, input int b, input int w);
    return (abs_int(a) >= 2 * w - 1) && (abs_int(a) <= 2 * w + 1) && (abs_int(b) <= 2 * w + 1);
endfunction

// expected pixel at physical column c, row r
function automatic pixel_t model_pixel(input mode_t m, input theta_t th, input int c, input int r);
    int dx;
    int dy;
    int w;
    int h;
    pixel_t px;
    dx = 2 * c - 63;              // doubled, so always odd
    dy = 2 * r - 63;
    w  = 16 + int'(th[4:0]) / 2;  // breathing half-width
    h  = (37 * r + 11 * c + int'(th)) % 256;
    case (m)
        MODE_CYLINDER: px = {th[7:5], th[4:2], th[1:0], 1'b1};
        MODE_SPHERE:   px = (dx * dx + dy * dy <= 3969) ? SPHERE_COLOR : 9'h000;
        MODE_CUBE:     px = (on_side(dx, dy, w) || on_side(dy, dx, w)) ? CUBE_COLOR : 9'h000;
        default:       px = (h < 8) ? STAR_COLOR : 9'h000;  // top five hash bits clear
    endcase
    return px;
endfunction

`endif

// File: testbench/tb_pov_display.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pov_display
    import pov_pkg::*;
();

    localparam int CLK_HALF       = 2;      // 4 ns period
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 60000;  // 147 pairs at most ~170 cycles each, 2.4x margin

    logic     clk_in = 1'b0;
    logic     rst_in;
    mode_t    mode;
    theta_t   dtheta;
    pixel_t   hub_rgb0;
    pixel_t   hub_rgb1;
    logic     hub_clk;
    logic     hub_lat;
    logic     hub_oe;
    col_idx_t hub_addr;

    col_pair_t   cap_cols;              // rows shifted in so far
    col_pair_t   lat_cols;              // last latched pair
    col_idx_t    lat_addr;
    int          clk_pulses  = 0;
    int          lat_count   = 0;
    int          next_start  = 0;       // where the scan resumes
    int          cycle_count = 0;
    int          fail_count  = 0;
    logic        oe_seen     = 1'b0;    // first pair has started
    logic [31:0] rng_state   = 32'hfacf_6705;

    `include "tb_pov_models.svh"

    pov_display_top pov_display_top_inst (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .mode     (mode),
        .dtheta   (dtheta),
        .hub_rgb0 (hub_rgb0),
        .hub_rgb1 (hub_rgb1),
        .hub_clk  (hub_clk),
        .hub_lat  (hub_lat),
        .hub_oe   (hub_oe),
        .hub_addr (hub_addr)
    );

    always #CLK_HALF clk_in = ~clk_in;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        fail_count++;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    // panel side sampled on the falling edge
    always @(negedge clk_in) begin
        if (rst_in) begin
            assert (!hub_lat) else
                report_error($sformatf("ERROR hub_lat expected 0 got %h", hub_lat));
            assert (!hub_clk) else
                report_error($sformatf("ERROR hub_clk expected 0 got %h", hub_clk));
            assert (hub_oe) else report_error($sformatf("ERROR hub_oe expected 1 got %h", hub_oe));
            clk_pulses = 0;
        end else begin
            if (!hub_oe) oe_seen = 1'b1;
            if (oe_seen) begin  // blanked only while latching
                assert (hub_oe == hub_lat) else
                    report_error($sformatf("ERROR hub_oe expected %h got %h", hub_lat, hub_oe));
            end else begin
                assert (!hub_lat) else
                    report_error($sformatf("ERROR hub_lat expected 0 got %h", hub_lat));
                assert (!hub_clk) else
                    report_error($sformatf("ERROR hub_clk expected 0 got %h", hub_clk));
            end
            if (hub_clk) begin
                if (clk_pulses < NUM_ROWS) begin
                    cap_cols[0][clk_pulses] = hub_rgb0;
                    cap_cols[1][clk_pulses] = hub_rgb1;
                end
                clk_pulses++;
            end
            if (hub_lat) begin
                assert (clk_pulses == NUM_ROWS) else
                    report_error($sformatf("ERROR hub_clk pulses expected %h got %h",
                                           NUM_ROWS, clk_pulses));
                lat_cols   = cap_cols;
                lat_addr   = hub_addr;
                clk_pulses = 0;
                lat_count++;  // wakes the waiting test
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no further latched columns after %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    // address follows the scan order, pixels follow the scene rule
    task automatic check_pair(input mode_t m, input theta_t th);
        col_idx_t exp_addr;
        pixel_t   exp_px;
        exp_addr = next_refreshed(th, next_start);
        assert (lat_addr == exp_addr) else
            report_error($sformatf("ERROR hub_addr expected %h got %h", exp_addr, lat_addr));
        for (int k = 0; k < 2; k++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                exp_px = model_pixel(m, th, int'(lat_addr) + k * SCAN_RATE, r);
                assert (lat_cols[k][r] == exp_px) else
                    report_error($sformatf("ERROR hub_rgb%0d row %0d expected %h got %h",
                                           k, r, exp_px, lat_cols[k][r]));
            end
        end
        next_start = int'(lat_addr) + 1;
    endtask

    // new inputs right after a latch and before the scan rearms
    task automatic latch_and_check(input mode_t m, input theta_t th);
        int seen;
        @(posedge clk_in);
        mode   <= m;
        dtheta <= th;
        seen = lat_count;
        wait (lat_count != seen);
        check_pair(m, th);
    endtask

    task automatic first_pair_after_reset();
        latch_and_check(MODE_CYLINDER, 8'h06);  // 6 skips the two inner rings so the first is 16
    endtask

    task automatic scanline_mask();
        repeat (SCAN_RATE) latch_and_check(MODE_CYLINDER, 8'h00);  // every pair
        repeat (8) latch_and_check(MODE_CYLINDER, 8'h01);          // outer ring only
        repeat (24) latch_and_check(MODE_CYLINDER, 8'h04);         // all but the inner ring
    endtask

    task automatic scene_pixels();
        for (int m = 0; m < 4; m++) begin
            repeat (8) latch_and_check(mode_t'(m), 8'h5a);
            repeat (8) begin
                rng_state = xorshift32(rng_state);
                latch_and_check(mode_t'(m), rng_state[7:0]);
            end
        end
    endtask

    // angle flips every pair between cube width 16 and 31 with the hash shifted by 0x1e
    task automatic angle_change();
        mode_t scenes [3] = '{MODE_CUBE, MODE_STARFIELD, MODE_SPHERE};
        foreach (scenes[s]) begin
            repeat (3) begin
                latch_and_check(scenes[s], 8'h00);
                latch_and_check(scenes[s], 8'h1e);
            end
        end
    endtask

    initial begin
        rst_in <= 1'b1;
        mode   <= MODE_CYLINDER;
        dtheta <= 8'h06;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
        first_pair_after_reset();
        scanline_mask();
        scene_pixels();
        angle_change();
        if (fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
